//--- src/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

////////////////////////////////////////
// datapath sizing
////////////////////////////////////////

// data and instruction word width.
`define CPU_DATA_W 16

// general purpose registers.
`define CPU_NREGS 16

////////////////////////////////////////
// data memory
////////////////////////////////////////

`define CPU_RAM_AW 8       // word address bits.
`define CPU_RAM_DEPTH 256  // words.

`endif

//--- src/cpuPkg.sv
`include "cpu_consts.svh"

package cpuPkg;

	// alu operation select.
	typedef enum logic [3:0] {
		ADD,
		SUB,
		CMP,
		AND,
		OR,
		XOR,
		NOT,
		LSH,
		RSH,
		ARSH,
		MUL
	} aluOpE;

	typedef enum logic [3:0] {
		FETCH,
		DECODE,
		REG_READ,
		REG_EXEC,
		IMM_EXEC,
		MEM_ADDR,
		LOAD_WAIT,
		LOAD_WB,
		STORE,
		MEM_DONE,
		SCOND,
		BRANCH,
		JUMP
	} fsmStateE;

	typedef struct packed {
		logic [3:0] opcode;
		logic [3:0] rdest;
		logic [3:0] ext;
		logic [3:0] rsrc;
	} instrT;

	// msb first, c sits in bit 0.
	typedef struct packed {
		logic n;
		logic z;
		logic f;
		logic l;
		logic c;
	} flagsT;

	typedef enum logic [1:0] {PC_NEXT, PC_BRANCH, PC_JUMP, PC_HOLD} pcSelE;

	typedef enum logic [1:0] {WB_ALU, WB_RAM, WB_COND} wbSelE;

	typedef struct packed {
		logic regWe;
		logic ramWe;
		logic flagWe;
		logic immSel;      // operand b from imm.
		logic signExt;
		aluOpE aluOp;
		wbSelE wbSel;
		logic [3:0] rdestIdx;
		logic [3:0] rsrcIdx;
		logic [7:0] imm;   // also the branch displacement.
		logic pcEn;
		pcSelE pcSel;
	} ctrlT;

	typedef struct packed {
		logic valid;
		logic [3:0] regIdx;
		logic [`CPU_DATA_W-1:0] data;
	} wbT;

endpackage

//--- src/controlFsm.sv
module controlFsm (
	input logic Clk,
	input logic rstN,
	input cpuPkg::instrT instr,
	input cpuPkg::flagsT aluFlags,
	input logic condTrue,
	output cpuPkg::ctrlT ctrl,
	output logic [3:0] condCode,
	output cpuPkg::flagsT flags,
	output cpuPkg::fsmStateE state
);

	cpuPkg::fsmStateE nextState;
	cpuPkg::instrT ir;
	cpuPkg::aluOpE aluOpSel;
	logic isRegForm;
	logic isLoad;

	////////////////////////////////////////
	// decode helpers
	////////////////////////////////////////

	// ext or opcode values shared by the register and immediate forms.
	function automatic logic isAluCode(logic [3:0] code);
		case (code)
			4'b0101, 4'b1001, 4'b1011, 4'b0001, 4'b0010, 4'b0011, 4'b1110: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic cpuPkg::aluOpE opFromCode(logic [3:0] code);
		case (code)
			4'b0101, 4'b0110: return cpuPkg::ADD; // addui lands here too.
			4'b1001: return cpuPkg::SUB;
			4'b1011: return cpuPkg::CMP;
			4'b0001: return cpuPkg::AND;
			4'b0010: return cpuPkg::OR;
			4'b0011: return cpuPkg::XOR;
			4'b1110: return cpuPkg::MUL;
			default: return cpuPkg::LSH;
		endcase
	endfunction

	function automatic logic isAluInstr(cpuPkg::instrT i);
		logic regOk;
		logic immOk;
		regOk = (i.opcode == 4'b0000 && isAluCode(i.ext)) ||
			(i.opcode == 4'b1000 && i.ext == 4'b0100);
		immOk = isAluCode(i.opcode) || i.opcode == 4'b0110;
		return regOk || immOk;
	endfunction

	// bcond and jcond leave the pc alone in decode.
	function automatic logic isFlowInstr(cpuPkg::instrT i);
		return i.opcode == 4'b1100 || (i.opcode == 4'b0100 && i.ext == 4'b1100);
	endfunction

	assign isRegForm = (ir.opcode == 4'b0000) || (ir.opcode == 4'b1000);
	assign isLoad = (ir.ext == 4'b0000);
	assign aluOpSel = (ir.opcode == 4'b1000) ? cpuPkg::LSH :
		isRegForm ? opFromCode(ir.ext) : opFromCode(ir.opcode);

	// scond keeps its condition in rsrc.
	assign condCode = (ir.opcode == 4'b0100 && ir.ext == 4'b1101) ? ir.rsrc : ir.rdest;

	////////////////////////////////////////
	// state, instruction and flag registers
	////////////////////////////////////////

	always_ff @(posedge Clk) begin
		if (!rstN) begin
			state <= cpuPkg::FETCH;
			ir <= '0;
			flags <= '0;
		end else begin
			state <= nextState;
			if (state == cpuPkg::DECODE)
				ir <= instr; // fetch data is valid through decode.
			if (ctrl.flagWe)
				flags <= aluFlags;
		end
	end

	always_comb begin
		case (state)
			cpuPkg::FETCH: nextState = cpuPkg::DECODE;
			cpuPkg::DECODE: begin
				if (isAluInstr(instr))
					nextState = cpuPkg::REG_READ;
				else if (instr.opcode == 4'b1100)
					nextState = cpuPkg::BRANCH;
				else if (instr.opcode == 4'b0100) begin
					case (instr.ext)
						4'b0000, 4'b0100: nextState = cpuPkg::MEM_ADDR;
						4'b1101: nextState = cpuPkg::SCOND;
						4'b1100: nextState = cpuPkg::JUMP;
						default: nextState = cpuPkg::FETCH;
					endcase
				end else
					nextState = cpuPkg::FETCH; // unused encoding.
			end
			cpuPkg::REG_READ: nextState = isRegForm ? cpuPkg::REG_EXEC : cpuPkg::IMM_EXEC;
			cpuPkg::MEM_ADDR: nextState = isLoad ? cpuPkg::LOAD_WAIT : cpuPkg::STORE;
			cpuPkg::LOAD_WAIT: nextState = cpuPkg::MEM_DONE;
			cpuPkg::STORE: nextState = cpuPkg::MEM_DONE;
			cpuPkg::MEM_DONE: nextState = isLoad ? cpuPkg::LOAD_WB : cpuPkg::FETCH;
			default: nextState = cpuPkg::FETCH;
		endcase
	end

	////////////////////////////////////////
	// control word
	////////////////////////////////////////

	always_comb begin
		ctrl = '0;
		ctrl.aluOp = aluOpSel;
		ctrl.wbSel = cpuPkg::WB_ALU;
		ctrl.pcSel = cpuPkg::PC_HOLD;
		ctrl.rdestIdx = ir.rdest;
		ctrl.rsrcIdx = ir.rsrc;
		ctrl.imm = {ir.ext, ir.rsrc};
		ctrl.signExt = (ir.opcode != 4'b0110);
		case (state)
			cpuPkg::DECODE: begin
				if (!isFlowInstr(instr)) begin
					ctrl.pcEn = 1'b1;
					ctrl.pcSel = cpuPkg::PC_NEXT;
				end
			end
			cpuPkg::REG_EXEC: begin
				ctrl.flagWe = 1'b1;
				ctrl.regWe = (aluOpSel != cpuPkg::CMP);
			end
			cpuPkg::IMM_EXEC: begin
				ctrl.immSel = 1'b1;
				ctrl.flagWe = 1'b1;
				ctrl.regWe = (aluOpSel != cpuPkg::CMP);
			end
			cpuPkg::STORE: ctrl.ramWe = 1'b1;
			cpuPkg::LOAD_WB: begin
				ctrl.regWe = 1'b1;
				ctrl.wbSel = cpuPkg::WB_RAM;
			end
			cpuPkg::SCOND: begin
				ctrl.regWe = 1'b1;
				ctrl.wbSel = cpuPkg::WB_COND;
			end
			cpuPkg::BRANCH: begin
				ctrl.pcEn = 1'b1;
				ctrl.pcSel = condTrue ? cpuPkg::PC_BRANCH : cpuPkg::PC_NEXT;
			end
			cpuPkg::JUMP: begin
				ctrl.pcEn = 1'b1;
				ctrl.pcSel = condTrue ? cpuPkg::PC_JUMP : cpuPkg::PC_NEXT;
			end
			default: ;
		endcase
	end

endmodule

//--- src/condDecoder.sv
module condDecoder (
	input logic [3:0] condCode,
	input cpuPkg::flagsT flags,
	output logic condTrue
);

	always_comb begin
		case (condCode)
			4'd0: condTrue = flags.z;                 // eq.
			4'd1: condTrue = !flags.z;
			4'd2: condTrue = flags.c;
			4'd3: condTrue = !flags.c;
			4'd4: condTrue = flags.l;                 // unsigned lower.
			4'd5: condTrue = !flags.l;
			4'd6: condTrue = flags.n;
			4'd7: condTrue = !flags.n;
			4'd8: condTrue = flags.f;
			4'd9: condTrue = !flags.f;
			4'd10: condTrue = !(flags.l || flags.z);
			4'd11: condTrue = flags.l || flags.z;
			4'd12: condTrue = !(flags.n || flags.z); // signed greater.
			4'd13: condTrue = flags.n || flags.z;
			4'd14: condTrue = 1'b1;
			default: condTrue = 1'b0;
		endcase
	end

endmodule

//--- src/alu.sv
`include "cpu_consts.svh"

module alu (
	input cpuPkg::aluOpE op,
	input logic [`CPU_DATA_W-1:0] a,
	input logic [`CPU_DATA_W-1:0] b,
	output logic [`CPU_DATA_W-1:0] result,
	output cpuPkg::flagsT flags
);

	localparam int MSB = `CPU_DATA_W - 1;

	logic [`CPU_DATA_W:0] sum;
	logic [`CPU_DATA_W:0] diff;
	logic [3:0] shAmt;

	assign sum = {1'b0, a} + {1'b0, b};
	assign diff = {1'b0, a} - {1'b0, b}; // top bit is the borrow.
	assign shAmt = b[3:0];

	always_comb begin
		case (op)
			cpuPkg::ADD: result = sum[MSB:0];
			cpuPkg::SUB, cpuPkg::CMP: result = diff[MSB:0];
			cpuPkg::AND: result = a & b;
			cpuPkg::OR: result = a | b;
			cpuPkg::XOR: result = a ^ b;
			cpuPkg::NOT: result = ~a;
			cpuPkg::LSH: result = a << shAmt;
			cpuPkg::RSH: result = a >> shAmt;
			cpuPkg::ARSH: result = $signed(a) >>> shAmt;
			cpuPkg::MUL: result = a * b; // low half only.
			default: result = '0;
		endcase
	end

	////////////////////////////////////////
	// flags
	////////////////////////////////////////

	always_comb begin
		flags = '0;
		flags.z = (result == '0);
		flags.n = result[MSB];
		case (op)
			cpuPkg::ADD: begin
				flags.c = sum[`CPU_DATA_W];
				flags.f = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);
			end
			cpuPkg::SUB: begin
				flags.c = diff[`CPU_DATA_W];
				flags.f = (a[MSB] != b[MSB]) && (diff[MSB] != a[MSB]);
			end
			cpuPkg::CMP: begin
				flags.c = diff[`CPU_DATA_W];
				flags.f = (a[MSB] != b[MSB]) && (diff[MSB] != a[MSB]);
				flags.z = (a == b);
				flags.l = diff[`CPU_DATA_W];             // unsigned below.
				flags.n = ($signed(a) < $signed(b));
			end
			default: ;
		endcase
	end

endmodule

//--- src/regFile.sv
`include "cpu_consts.svh"

module regFile (
	input logic Clk,
	input logic rstN,
	input logic we,
	input logic [3:0] wIdx,
	input logic [`CPU_DATA_W-1:0] wData,
	input logic [3:0] rdestIdx,
	input logic [3:0] rsrcIdx,
	output logic [`CPU_DATA_W-1:0] rdestData,
	output logic [`CPU_DATA_W-1:0] rsrcData
);

	logic [`CPU_DATA_W-1:0] regs [`CPU_NREGS];

	always_ff @(posedge Clk) begin
		if (!rstN) begin
			for (int i = 0; i < `CPU_NREGS; i++)
				regs[i] <= '0;
		end else if (we)
			regs[wIdx] <= wData;
	end

	// reads are combinational.
	assign rdestData = regs[rdestIdx];
	assign rsrcData = regs[rsrcIdx];

endmodule

//--- src/pcUnit.sv
`include "cpu_consts.svh"

module pcUnit (
	input logic Clk,
	input logic rstN,
	input logic pcEn,
	input cpuPkg::pcSelE pcSel,
	input logic [7:0] disp,
	input logic [`CPU_DATA_W-1:0] jumpTarget,
	output logic [`CPU_DATA_W-1:0] pc
);

	logic [`CPU_DATA_W-1:0] dispExt;

	assign dispExt = {{(`CPU_DATA_W - 8){disp[7]}}, disp};

	always_ff @(posedge Clk) begin
		if (!rstN)
			pc <= '0;
		else if (pcEn) begin
			case (pcSel)
				cpuPkg::PC_NEXT: pc <= pc + 1'b1;
				cpuPkg::PC_BRANCH: pc <= pc + dispExt; // pc still holds the branch address.
				cpuPkg::PC_JUMP: pc <= jumpTarget;
				default: pc <= pc;
			endcase
		end
	end

endmodule

//--- src/dataRam.sv
`include "cpu_consts.svh"

module dataRam (
	input logic Clk,
	input logic we,
	input logic [`CPU_RAM_AW-1:0] addr,
	input logic [`CPU_DATA_W-1:0] wData,
	output logic [`CPU_DATA_W-1:0] rData
);

	logic [`CPU_DATA_W-1:0] mem [`CPU_RAM_DEPTH];

	always_ff @(posedge Clk) begin
		if (we)
			mem[addr] <= wData;
		rData <= mem[addr]; // one cycle read latency.
	end

endmodule

//--- src/cpuTop.sv
`include "cpu_consts.svh"

module cpuTop (
	input logic Clk,
	input logic rstN,
	input cpuPkg::instrT instr,
	output logic fetchReq,
	output logic [`CPU_DATA_W-1:0] fetchAddr,
	output cpuPkg::wbT wb
);

	cpuPkg::ctrlT ctrl;
	cpuPkg::flagsT aluFlags;
	cpuPkg::flagsT savedFlags;
	cpuPkg::fsmStateE state;
	logic [3:0] condCode;
	logic condTrue;
	logic [`CPU_DATA_W-1:0] rdestData;
	logic [`CPU_DATA_W-1:0] rsrcData;
	logic [`CPU_DATA_W-1:0] immExt;
	logic [`CPU_DATA_W-1:0] operandB;
	logic [`CPU_DATA_W-1:0] aluResult;
	logic [`CPU_DATA_W-1:0] ramData;
	logic [`CPU_DATA_W-1:0] wData;

	////////////////////////////////////////
	// control
	////////////////////////////////////////

	controlFsm i_fsm (
		.Clk(Clk),
		.rstN(rstN),
		.instr(instr),
		.aluFlags(aluFlags),
		.condTrue(condTrue),
		.ctrl(ctrl),
		.condCode(condCode),
		.flags(savedFlags),
		.state(state)
	);

	condDecoder i_condDec (
		.condCode(condCode),
		.flags(savedFlags),
		.condTrue(condTrue)
	);

	// held low while in reset.
	assign fetchReq = rstN && (state == cpuPkg::FETCH);

	////////////////////////////////////////
	// datapath
	////////////////////////////////////////

	assign immExt = ctrl.signExt ? {{(`CPU_DATA_W - 8){ctrl.imm[7]}}, ctrl.imm} :
		{{(`CPU_DATA_W - 8){1'b0}}, ctrl.imm};
	assign operandB = ctrl.immSel ? immExt : rsrcData;

	alu i_alu (
		.op(ctrl.aluOp),
		.a(rdestData),
		.b(operandB),
		.result(aluResult),
		.flags(aluFlags)
	);

	always_comb begin
		case (ctrl.wbSel)
			cpuPkg::WB_RAM: wData = ramData;
			cpuPkg::WB_COND: wData = {{(`CPU_DATA_W - 1){1'b0}}, condTrue};
			default: wData = aluResult;
		endcase
	end

	regFile i_regs (
		.Clk(Clk),
		.rstN(rstN),
		.we(ctrl.regWe),
		.wIdx(ctrl.rdestIdx),
		.wData(wData),
		.rdestIdx(ctrl.rdestIdx),
		.rsrcIdx(ctrl.rsrcIdx),
		.rdestData(rdestData),
		.rsrcData(rsrcData)
	);

	// address from rsrc, store data from rdest.
	dataRam i_ram (
		.Clk(Clk),
		.we(ctrl.ramWe),
		.addr(rsrcData[`CPU_RAM_AW-1:0]),
		.wData(rdestData),
		.rData(ramData)
	);

	pcUnit i_pc (
		.Clk(Clk),
		.rstN(rstN),
		.pcEn(ctrl.pcEn),
		.pcSel(ctrl.pcSel),
		.disp(ctrl.imm),
		.jumpTarget(rsrcData),
		.pc(fetchAddr)
	);

	assign wb = '{valid: ctrl.regWe, regIdx: ctrl.rdestIdx, data: wData};

endmodule

//--- dv/clkGen.sv
module clkGen (
	output logic Clk,
	output logic rstN
);

	timeunit 1ns;
	timeprecision 100ps;

	initial Clk = 1'b0;
	always #20 Clk = ~Clk; // 40 ns period.

	initial begin
		rstN = 1'b0;
		repeat (2) @(posedge Clk);
		rstN <= 1'b1;
	end

endmodule

//--- dv/tbCpu.sv
`include "cpu_consts.svh"

module tbCpu;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int PROG_LEN = 64;
	localparam int CLK_NS = 40;

	logic Clk;
	logic rstN;
	cpuPkg::instrT instr;
	logic fetchReq;
	logic [`CPU_DATA_W-1:0] fetchAddr;
	cpuPkg::wbT wb;

	logic [15:0] prog [PROG_LEN];
	string progName [PROG_LEN];
	int progLen;
	logic [15:0] expFetch [$];
	string expWbName [$];
	logic [3:0] expWbIdx [$];
	logic [15:0] expWbData [$];
	int fetchPtr;
	int wbPtr;
	int errors;
	int nFetch;
	logic [31:0] rngState;

	clkGen i_clk (.Clk(Clk), .rstN(rstN));

	cpuTop i_dut (
		.Clk(Clk),
		.rstN(rstN),
		.instr(instr),
		.fetchReq(fetchReq),
		.fetchAddr(fetchAddr),
		.wb(wb)
	);

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	function automatic logic [31:0] xorshift(logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic logic [7:0] nextImm();
		rngState = xorshift(rngState);
		return rngState[7:0];
	endfunction

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			errors++;
			$display("CHECK FAILED %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic addInstr(input string name, input logic [15:0] word);
		prog[progLen] = word;
		progName[progLen] = $sformatf("%s @%0d", name, progLen);
		progLen++;
	endtask

	// flags packed as {n, z, f, l, c}; code 4'hf stands for lsh.
	task automatic aluModel(input logic [3:0] code, input logic [15:0] a, input logic [15:0] b,
		output logic [15:0] r, output logic [4:0] fl);
		logic n;
		logic z;
		logic f;
		logic l;
		logic c;
		logic [16:0] wide;
		f = 1'b0;
		l = 1'b0;
		c = 1'b0;
		case (code)
			4'b0101, 4'b0110: begin
				wide = a + b;
				r = wide[15:0];
				c = wide[16];
				f = (a[15] == b[15]) && (r[15] != a[15]);
			end
			4'b1001, 4'b1011: begin
				r = a - b;
				c = (a < b); // borrow.
				f = (a[15] != b[15]) && (r[15] != a[15]);
			end
			4'b0001: r = a & b;
			4'b0010: r = a | b;
			4'b0011: r = a ^ b;
			4'b1110: r = 16'(a * b);
			default: r = a << b[3:0];
		endcase
		z = (r == 16'd0);
		n = r[15];
		if (code == 4'b1011) begin
			z = (a == b);
			l = (a < b);
			n = ($signed(a) < $signed(b));
		end
		fl = {n, z, f, l, c};
	endtask

	function automatic logic condHolds(logic [3:0] code, logic [4:0] fl);
		logic n;
		logic z;
		logic f;
		logic l;
		logic c;
		logic base;
		{n, z, f, l, c} = fl;
		case (code[3:1])
			3'd0: base = z;
			3'd1: base = c;
			3'd2: base = l;
			3'd3: base = n;
			3'd4: base = f;
			3'd5: base = l | z;
			3'd6: base = n | z;
			default: base = 1'b0; // 14 and 15 handled below.
		endcase
		if (code == 4'd14)
			return 1'b1;
		if (code == 4'd15)
			return 1'b0;
		if (code == 4'd10 || code == 4'd12)
			return !base;
		if (code == 4'd11 || code == 4'd13)
			return base;
		return code[0] ? !base : base;
	endfunction

	////////////////////////////////////////
	// program table
	////////////////////////////////////////

	task automatic buildProgram();
		addInstr("ADDUI", {4'b0110, 4'd1, nextImm()});
		addInstr("ADDI", {4'b0101, 4'd2, nextImm()});
		addInstr("SUBI", {4'b1001, 4'd3, nextImm()});
		addInstr("ANDI", {4'b0001, 4'd1, nextImm()});
		addInstr("ORI", {4'b0010, 4'd2, nextImm()});
		addInstr("XORI", {4'b0011, 4'd3, nextImm()});
		addInstr("MULI", {4'b1110, 4'd2, nextImm()});
		addInstr("ADD", {4'b0000, 4'd1, 4'b0101, 4'd2});
		addInstr("SUB", {4'b0000, 4'd3, 4'b1001, 4'd1});
		addInstr("AND", {4'b0000, 4'd2, 4'b0001, 4'd3});
		addInstr("OR", {4'b0000, 4'd1, 4'b0010, 4'd3});
		addInstr("XOR", {4'b0000, 4'd3, 4'b0011, 4'd2});
		addInstr("MUL", {4'b0000, 4'd2, 4'b1110, 4'd1});
		addInstr("ADDUI", {4'b0110, 4'd4, nextImm()});
		addInstr("LSH", {4'b1000, 4'd1, 4'b0100, 4'd4});
		addInstr("CMP", {4'b0000, 4'd1, 4'b1011, 4'd2});
		for (int k = 0; k < 8; k++)
			addInstr($sformatf("SCOND c%0d", k), {4'b0100, 4'(8 + k), 4'b1101, 4'(k)});
		addInstr("CMPI", {4'b1011, 4'd3, nextImm()});
		for (int k = 8; k < 16; k++)
			addInstr($sformatf("SCOND c%0d", k), {4'b0100, 4'(k), 4'b1101, 4'(k)});
		addInstr("ADDUI", {4'b0110, 4'd6, nextImm()});
		addInstr("STOR", {4'b0100, 4'd1, 4'b0100, 4'd6});
		addInstr("LOAD", {4'b0100, 4'd7, 4'b0000, 4'd6});
		// taken forward and backward branches and one that is not.
		addInstr("B fwd", {4'b1100, 4'd14, 8'sd3});
		addInstr("B fwd2", {4'b1100, 4'd14, 8'sd3});
		addInstr("ADDI skip", {4'b0101, 4'd5, 8'd1});
		addInstr("B back", {4'b1100, 4'd14, -8'sd2});
		addInstr("B never", {4'b1100, 4'd15, 8'sd5});
		addInstr("ADDUI", {4'b0110, 4'd5, 8'(progLen + 3)});
		addInstr("J", {4'b0100, 4'd14, 4'b1100, 4'd5});
		addInstr("ADDI skip", {4'b0101, 4'd5, 8'd1});
		addInstr("HALT", {4'b1100, 4'd14, 8'd0}); // branch to itself.
	endtask

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////

	task automatic runModel();
		logic [15:0] mReg [16];
		logic [15:0] mMem [256];
		logic [4:0] fl;
		logic [4:0] newFl;
		logic [15:0] pc;
		logic [15:0] w;
		logic [15:0] r;
		logic [15:0] b;
		logic [3:0] op;
		logic [3:0] rd;
		logic [3:0] ex;
		logic [3:0] rs;
		logic isImm;
		logic isReg;
		logic halted;
		foreach (mReg[k]) mReg[k] = 16'd0;
		foreach (mMem[k]) mMem[k] = 16'd0;
		fl = 5'd0;
		pc = 16'd0;
		halted = 1'b0;
		for (int step = 0; step < 200 && !halted; step++) begin
			expFetch.push_back(pc);
			w = prog[pc];
			{op, rd, ex, rs} = w;
			isReg = (op == 4'b0000 && ex inside {4'b0101, 4'b1001, 4'b1011, 4'b0001,
				4'b0010, 4'b0011, 4'b1110}) || (op == 4'b1000 && ex == 4'b0100);
			isImm = op inside {4'b0101, 4'b0110, 4'b1001, 4'b1011, 4'b0001, 4'b0010,
				4'b0011, 4'b1110};
			if (isReg || isImm) begin
				if (isReg)
					b = mReg[rs];
				else if (op == 4'b0110)
					b = {8'd0, ex, rs};
				else
					b = {{8{ex[3]}}, ex, rs};
				aluModel(isReg ? (op == 4'b1000 ? 4'hf : ex) : op, mReg[rd], b, r, newFl);
				fl = newFl;
				if ((isReg ? ex : op) != 4'b1011) begin
					mReg[rd] = r;
					expWbName.push_back(progName[pc]);
					expWbIdx.push_back(rd);
					expWbData.push_back(r);
				end
				pc++;
			end else if (op == 4'b1100) begin
				if (condHolds(rd, fl)) begin
					halted = ({ex, rs} == 8'd0);
					pc = pc + {{8{ex[3]}}, ex, rs};
				end else
					pc++;
			end else if (op == 4'b0100 && ex == 4'b1100) begin
				pc = condHolds(rd, fl) ? mReg[rs] : pc + 16'd1;
			end else if (op == 4'b0100 && (ex == 4'b0000 || ex == 4'b1101)) begin
				mReg[rd] = (ex == 4'b0000) ? mMem[mReg[rs][7:0]] : {15'd0, condHolds(rs, fl)};
				expWbName.push_back(progName[pc]);
				expWbIdx.push_back(rd);
				expWbData.push_back(mReg[rd]);
				pc++;
			end else if (op == 4'b0100 && ex == 4'b0100) begin
				mMem[mReg[rs][7:0]] = mReg[rd];
				pc++;
			end else
				pc++;
		end
	endtask

	////////////////////////////////////////
	// fetch port and monitor
	////////////////////////////////////////

	always @(posedge Clk) begin
		if (!rstN) begin
			check("fetchReq in reset", 0, fetchReq);
			check("writeback in reset", 0, wb.valid);
		end else begin
			if (fetchReq) begin
				instr <= (fetchAddr < PROG_LEN) ? prog[fetchAddr] : 16'd0;
				if (fetchPtr == 0)
					check("no writeback before first fetch", 0, wbPtr);
				if (fetchPtr < nFetch) begin
					check($sformatf("fetch %0d", fetchPtr), expFetch[fetchPtr], fetchAddr);
					fetchPtr++;
				end
			end
			if (wb.valid) begin
				if (wbPtr < expWbIdx.size()) begin
					check({expWbName[wbPtr], " idx"}, expWbIdx[wbPtr], wb.regIdx);
					check({expWbName[wbPtr], " data"}, expWbData[wbPtr], wb.data);
				end else begin
					errors++;
					$display("unexpected writeback to r%0d", wb.regIdx);
				end
				wbPtr++;
			end
		end
	end

	// 8 cycles per fetch plus slack.
	initial begin
		wait (nFetch > 0);
		#((8 * nFetch + 100) * CLK_NS);
		$display("timeout: the program did not finish in time");
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		instr = '0;
		progLen = 0;
		fetchPtr = 0;
		wbPtr = 0;
		errors = 0;
		nFetch = 0;
		rngState = 32'hdcac_9050;
		for (int k = 0; k < PROG_LEN; k++) begin
			prog[k] = 16'd0;
			progName[k] = "unused";
		end
		buildProgram();
		runModel();
		nFetch = expFetch.size();
		while (fetchPtr < nFetch)
			@(posedge Clk);
		repeat (2) @(posedge Clk);
		check("writeback count", expWbIdx.size(), wbPtr);
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+src
src/cpuPkg.sv
src/controlFsm.sv
src/condDecoder.sv
src/alu.sv
src/regFile.sv
src/pcUnit.sv
src/dataRam.sv
src/cpuTop.sv
dv/clkGen.sv
dv/tbCpu.sv

//--- run.sh
#!/bin/bash
# build and run the cpu testbench with verilator, then scan the log.
rm -rf obj_dir sim.log build.log

verilator --binary --timing -Wno-fatal -Isrc -f verilog.f --top-module tbCpu \
	-o simCpu > build.log 2>&1 \
	&& ./obj_dir/simCpu > sim.log 2>&1 \
	|| echo "ERRORS FOUND" >> sim.log

cat sim.log
grep -q "ERRORS FOUND" sim.log && exit 1 || exit 0
